//--- logic/refill_cfg.svh
`ifndef REFILL_CFG_SVH
`define REFILL_CFG_SVH

// Bus widths shared by the sequencer and both read ports
`define REFILL_ADDR_W 32
`define REFILL_DATA_W 32

// Beats per cacheable line
// Instruction refills always use this length
`define REFILL_LINE_BEATS 4

// Upper 16 address bits of the uncached I/O segment
// Data refills in this segment fetch one beat only
`define REFILL_UNCACHED_SEG 16'h1000

`endif

//--- logic/axi_pkg.sv
`default_nettype none

package axi_pkg;

    // AR channel field types
    typedef logic [3:0] axi_id_t;

    // Beats minus one
    typedef logic [3:0] axi_len_t;

    // Bytes per beat
    typedef enum logic [2:0] {
        AXI_SIZE_BYTE  = 3'b000,
        AXI_SIZE_HALF  = 3'b001,
        AXI_SIZE_WORD  = 3'b010
    } axi_size_e;

    // Burst address behaviour
    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01,
        AXI_BURST_WRAP  = 2'b10
    } axi_burst_e;

    // Single ID for every refill, one outstanding read per port
    localparam axi_id_t AXI_ID_REFILL = 4'd0;

endpackage : axi_pkg

`default_nettype wire

//--- logic/refill_pkg.sv
`default_nettype none

`include "refill_cfg.svh"

package refill_pkg;

    // Refill side address and data word
    typedef logic [`REFILL_ADDR_W-1:0] addr_t;
    typedef logic [`REFILL_DATA_W-1:0] word_t;

    // Read sequencer states
    // I_* serve the instruction port on M0
    // D_* serve the data port on M1
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        I_ADDR = 3'd1,
        I_DATA = 3'd2,
        D_ADDR = 3'd3,
        D_DATA = 3'd4
    } refill_state_e;

endpackage : refill_pkg

`default_nettype wire

//--- logic/refill_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module refill_arbiter (
    input  logic ACLK,
    input  logic ARESETn,

    // Refill requests
    input  logic ic_req_i,
    input  logic dc_req_i,

    // Phase ends reported by the read ports
    input  logic ic_ar_done_i,
    input  logic ic_line_done_i,
    input  logic dc_ar_done_i,
    input  logic dc_line_done_i,

    // Next phase decode towards the read ports
    output logic ic_ar_issue_o,
    output logic ic_r_collect_o,
    output logic dc_ar_issue_o,
    output logic dc_r_collect_o
);

    refill_pkg::refill_state_e state_r;
    refill_pkg::refill_state_e state_nxt;

    //////////////////////////////////////////////////////////////////////
    // State register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state_r <= refill_pkg::IDLE;
        end else begin
            state_r <= state_nxt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            // Instruction side wins a tie
            refill_pkg::IDLE: begin
                if (ic_req_i) begin
                    state_nxt = refill_pkg::I_ADDR;
                end else if (dc_req_i) begin
                    state_nxt = refill_pkg::D_ADDR;
                end
            end
            refill_pkg::I_ADDR: begin
                if (ic_ar_done_i) begin
                    state_nxt = refill_pkg::I_DATA;
                end
            end
            // Waiting data request goes straight to its address phase
            refill_pkg::I_DATA: begin
                if (ic_line_done_i) begin
                    state_nxt = dc_req_i ? refill_pkg::D_ADDR : refill_pkg::IDLE;
                end
            end
            refill_pkg::D_ADDR: begin
                if (dc_ar_done_i) begin
                    state_nxt = refill_pkg::D_DATA;
                end
            end
            // Mirror of I_DATA
            refill_pkg::D_DATA: begin
                if (dc_line_done_i) begin
                    state_nxt = ic_req_i ? refill_pkg::I_ADDR : refill_pkg::IDLE;
                end
            end
            default: begin
                state_nxt = refill_pkg::IDLE;
            end
        endcase
    end

    // Ports register these so bus signals follow the state edge
    assign ic_ar_issue_o  = (state_nxt == refill_pkg::I_ADDR);
    assign ic_r_collect_o = (state_nxt == refill_pkg::I_DATA);
    assign dc_ar_issue_o  = (state_nxt == refill_pkg::D_ADDR);
    assign dc_r_collect_o = (state_nxt == refill_pkg::D_DATA);

endmodule : refill_arbiter

`default_nettype wire

//--- logic/axi_read_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "refill_cfg.svh"

module axi_read_port #(
    // 0 always full lines, 1 single beat for uncached addresses
    parameter bit UNCACHED_CHECK = 1'b0
) (
    input  logic                   ACLK,
    input  logic                   ARESETn,

    // Phase control from the sequencer
    input  logic                   ar_issue_i,
    input  logic                   r_collect_i,
    input  refill_pkg::addr_t      req_addr_i,

    // AR channel
    output axi_pkg::axi_id_t       arid_o,
    output refill_pkg::addr_t      araddr_o,
    output axi_pkg::axi_len_t      arlen_o,
    output axi_pkg::axi_size_e     arsize_o,
    output axi_pkg::axi_burst_e    arburst_o,
    output logic                   arvalid_o,
    input  logic                   arready_i,

    // R channel
    input  refill_pkg::word_t      rdata_i,
    input  logic                   rlast_i,
    input  logic                   rvalid_i,
    output logic                   rready_o,

    // Beat strobes to the cache
    output logic                   beat_valid_o,
    output refill_pkg::word_t      beat_data_o,
    output logic                   beat_last_o,

    // Phase ends to the sequencer
    output logic                   ar_done_o,
    output logic                   line_done_o
);

    logic              uncached;
    logic              r_hs;
    axi_pkg::axi_len_t burst_len;

    // Segment compare on the top 16 address bits
    assign uncached  = UNCACHED_CHECK &&
                       (req_addr_i[`REFILL_ADDR_W-1 -: 16] == `REFILL_UNCACHED_SEG);
    assign burst_len = uncached ? axi_pkg::axi_len_t'(0)
                                : axi_pkg::axi_len_t'(`REFILL_LINE_BEATS - 1);

    //////////////////////////////////////////////////////////////////////
    // Address phase
    //////////////////////////////////////////////////////////////////////

    // Reloaded every cycle of the phase
    // Request address is stable so the fields hold until ARREADY
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            arid_o    <= '0;
            araddr_o  <= '0;
            arlen_o   <= '0;
            arsize_o  <= axi_pkg::AXI_SIZE_BYTE;
            arburst_o <= axi_pkg::AXI_BURST_FIXED;
            arvalid_o <= 1'b0;
        end else if (ar_issue_i) begin
            arid_o    <= axi_pkg::AXI_ID_REFILL;
            araddr_o  <= req_addr_i;
            arlen_o   <= burst_len;
            arsize_o  <= axi_pkg::AXI_SIZE_WORD;
            arburst_o <= axi_pkg::AXI_BURST_INCR;
            arvalid_o <= 1'b1;
        end else begin
            // Idle bus fields read as zero
            arid_o    <= '0;
            araddr_o  <= '0;
            arlen_o   <= '0;
            arsize_o  <= axi_pkg::AXI_SIZE_BYTE;
            arburst_o <= axi_pkg::AXI_BURST_FIXED;
            arvalid_o <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Data phase
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            rready_o <= 1'b0;
        end else begin
            rready_o <= r_collect_i;
        end
    end

    assign r_hs = rvalid_i & rready_o;

    // One strobe per accepted beat
    assign beat_valid_o = r_hs;
    assign beat_data_o  = rdata_i;
    assign beat_last_o  = r_hs & rlast_i;

    assign ar_done_o   = arvalid_o & arready_i;
    assign line_done_o = r_hs & rlast_i;

endmodule : axi_read_port

`default_nettype wire

//--- logic/refill_master_top.sv
`timescale 1ns/10ps
`default_nettype none

module refill_master_top (
    input  logic                   ACLK,
    input  logic                   ARESETn,

    // Instruction cache refill port
    input  logic                   ic_req_i,
    input  refill_pkg::addr_t      ic_addr_i,
    output logic                   ic_beat_valid_o,
    output refill_pkg::word_t      ic_beat_data_o,
    output logic                   ic_beat_last_o,

    // Data cache refill port
    input  logic                   dc_req_i,
    input  refill_pkg::addr_t      dc_addr_i,
    output logic                   dc_beat_valid_o,
    output refill_pkg::word_t      dc_beat_data_o,
    output logic                   dc_beat_last_o,

    // M0 read address
    output axi_pkg::axi_id_t       arid_m0_o,
    output refill_pkg::addr_t      araddr_m0_o,
    output axi_pkg::axi_len_t      arlen_m0_o,
    output axi_pkg::axi_size_e     arsize_m0_o,
    output axi_pkg::axi_burst_e    arburst_m0_o,
    output logic                   arvalid_m0_o,
    input  logic                   arready_m0_i,

    // M0 read data
    input  refill_pkg::word_t      rdata_m0_i,
    input  logic                   rlast_m0_i,
    input  logic                   rvalid_m0_i,
    output logic                   rready_m0_o,

    // M1 read address
    output axi_pkg::axi_id_t       arid_m1_o,
    output refill_pkg::addr_t      araddr_m1_o,
    output axi_pkg::axi_len_t      arlen_m1_o,
    output axi_pkg::axi_size_e     arsize_m1_o,
    output axi_pkg::axi_burst_e    arburst_m1_o,
    output logic                   arvalid_m1_o,
    input  logic                   arready_m1_i,

    // M1 read data
    input  refill_pkg::word_t      rdata_m1_i,
    input  logic                   rlast_m1_i,
    input  logic                   rvalid_m1_i,
    output logic                   rready_m1_o
);

    // Sequencer to port controls
    logic ic_ar_issue;
    logic ic_r_collect;
    logic dc_ar_issue;
    logic dc_r_collect;

    // Port to sequencer phase ends
    logic ic_ar_done;
    logic ic_line_done;
    logic dc_ar_done;
    logic dc_line_done;

    //////////////////////////////////////////////////////////////////////
    // Shared read sequencer
    //////////////////////////////////////////////////////////////////////

    refill_arbiter u_arbiter (
        .ACLK           (ACLK),
        .ARESETn        (ARESETn),
        .ic_req_i       (ic_req_i),
        .dc_req_i       (dc_req_i),
        .ic_ar_done_i   (ic_ar_done),
        .ic_line_done_i (ic_line_done),
        .dc_ar_done_i   (dc_ar_done),
        .dc_line_done_i (dc_line_done),
        .ic_ar_issue_o  (ic_ar_issue),
        .ic_r_collect_o (ic_r_collect),
        .dc_ar_issue_o  (dc_ar_issue),
        .dc_r_collect_o (dc_r_collect)
    );

    //////////////////////////////////////////////////////////////////////
    // M0 instruction refill with full lines only
    //////////////////////////////////////////////////////////////////////

    axi_read_port #(
        .UNCACHED_CHECK (1'b0)
    ) u_iport (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .ar_issue_i    (ic_ar_issue),
        .r_collect_i   (ic_r_collect),
        .req_addr_i    (ic_addr_i),
        .arid_o        (arid_m0_o),
        .araddr_o      (araddr_m0_o),
        .arlen_o       (arlen_m0_o),
        .arsize_o      (arsize_m0_o),
        .arburst_o     (arburst_m0_o),
        .arvalid_o     (arvalid_m0_o),
        .arready_i     (arready_m0_i),
        .rdata_i       (rdata_m0_i),
        .rlast_i       (rlast_m0_i),
        .rvalid_i      (rvalid_m0_i),
        .rready_o      (rready_m0_o),
        .beat_valid_o  (ic_beat_valid_o),
        .beat_data_o   (ic_beat_data_o),
        .beat_last_o   (ic_beat_last_o),
        .ar_done_o     (ic_ar_done),
        .line_done_o   (ic_line_done)
    );

    //////////////////////////////////////////////////////////////////////
    // M1 data refill with single beats in the I/O segment
    //////////////////////////////////////////////////////////////////////

    axi_read_port #(
        .UNCACHED_CHECK (1'b1)
    ) u_dport (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .ar_issue_i    (dc_ar_issue),
        .r_collect_i   (dc_r_collect),
        .req_addr_i    (dc_addr_i),
        .arid_o        (arid_m1_o),
        .araddr_o      (araddr_m1_o),
        .arlen_o       (arlen_m1_o),
        .arsize_o      (arsize_m1_o),
        .arburst_o     (arburst_m1_o),
        .arvalid_o     (arvalid_m1_o),
        .arready_i     (arready_m1_i),
        .rdata_i       (rdata_m1_i),
        .rlast_i       (rlast_m1_i),
        .rvalid_i      (rvalid_m1_i),
        .rready_o      (rready_m1_o),
        .beat_valid_o  (dc_beat_valid_o),
        .beat_data_o   (dc_beat_data_o),
        .beat_last_o   (dc_beat_last_o),
        .ar_done_o     (dc_ar_done),
        .line_done_o   (dc_line_done)
    );

endmodule : refill_master_top

`default_nettype wire

//--- sim/tb_refill_master.sv
`timescale 1ns/10ps
`default_nettype none

`include "refill_cfg.svh"

module tb_refill_master;

    localparam int NUM_REQ       = 40;
    localparam int MAX_CYCLES    = NUM_REQ * 64;
    localparam int RAND_PER_PORT = 16;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    // Per-port data scramble with M0 at index 0
    localparam logic [1:0][31:0] DATA_XOR = {32'h5a5a_0f0f, 32'h00c3_3c00};

    logic ACLK;
    logic ARESETn;

    // Refill side with the instruction port at index 0
    logic [1:0]       req_q;
    logic [1:0][31:0] addr_q;
    wire  [1:0]       beat_valid_w;
    wire  [1:0]       beat_last_w;
    wire  [1:0][31:0] beat_data_w;

    // Bus side with M0 at index 0
    wire  [1:0]       arvalid_w;
    wire  [1:0]       rready_w;
    wire  [1:0][31:0] araddr_w;
    wire  [1:0][3:0]  arid_w;
    wire  [1:0][3:0]  arlen_w;
    wire  [1:0][2:0]  arsize_w;
    wire  [1:0][1:0]  arburst_w;
    logic [1:0]       arready_q;
    logic [1:0]       rvalid_q;
    logic [1:0]       rlast_q;
    logic [1:0][31:0] rdata_q;

    // Slave model state
    logic [1:0]       m_busy;
    logic [1:0]       m_took;
    logic [1:0][3:0]  m_idx;
    logic [1:0][3:0]  m_len;
    logic [1:0][31:0] m_addr;

    logic [1:0][3:0]  beat_cnt;
    logic [31:0]      rnd_addr [2][RAND_PER_PORT];
    int unsigned      rnd_gap  [2][RAND_PER_PORT];
    logic [31:0]      lfsr_q    = 32'h9356_8f6a;
    int               error_cnt = 0;
    int               cycle_cnt = 0;

    refill_master_top u_dut (
        .ACLK            (ACLK),
        .ARESETn         (ARESETn),
        .ic_req_i        (req_q[0]),
        .ic_addr_i       (addr_q[0]),
        .ic_beat_valid_o (beat_valid_w[0]),
        .ic_beat_data_o  (beat_data_w[0]),
        .ic_beat_last_o  (beat_last_w[0]),
        .dc_req_i        (req_q[1]),
        .dc_addr_i       (addr_q[1]),
        .dc_beat_valid_o (beat_valid_w[1]),
        .dc_beat_data_o  (beat_data_w[1]),
        .dc_beat_last_o  (beat_last_w[1]),
        .arid_m0_o       (arid_w[0]),
        .araddr_m0_o     (araddr_w[0]),
        .arlen_m0_o      (arlen_w[0]),
        .arsize_m0_o     (arsize_w[0]),
        .arburst_m0_o    (arburst_w[0]),
        .arvalid_m0_o    (arvalid_w[0]),
        .arready_m0_i    (arready_q[0]),
        .rdata_m0_i      (rdata_q[0]),
        .rlast_m0_i      (rlast_q[0]),
        .rvalid_m0_i     (rvalid_q[0]),
        .rready_m0_o     (rready_w[0]),
        .arid_m1_o       (arid_w[1]),
        .araddr_m1_o     (araddr_w[1]),
        .arlen_m1_o      (arlen_w[1]),
        .arsize_m1_o     (arsize_w[1]),
        .arburst_m1_o    (arburst_w[1]),
        .arvalid_m1_o    (arvalid_w[1]),
        .arready_m1_i    (arready_q[1]),
        .rdata_m1_i      (rdata_q[1]),
        .rlast_m1_i      (rlast_q[1]),
        .rvalid_m1_i     (rvalid_q[1]),
        .rready_m1_o     (rready_w[1])
    );

    always #50 ACLK = ~ACLK;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Beats minus one
    // Single beat only for data refills in the I/O segment
    function automatic logic [3:0] expected_len(input int p, input logic [31:0] a);
        if (p == 1 && a[31:16] == `REFILL_UNCACHED_SEG) begin
            return 4'd0;
        end
        return 4'(`REFILL_LINE_BEATS - 1);
    endfunction

    // Word k of a line scrambled per port
    function automatic logic [31:0] expected_data(input int p, input logic [31:0] a,
                                                  input logic [3:0] k);
        return (a + (32'(k) << 2)) ^ DATA_XOR[p];
    endfunction

    task automatic flag_value(input string sig, input logic [31:0] got,
                              input logic [31:0] exp);
        error_cnt++;
        $display("FAILED %s: got 0x%h, expected 0x%h at %0t", sig, got, exp, $time);
    endtask

    task automatic flag_event(input string what);
        error_cnt++;
        $display("Check failed at %0t: %s", $time, what);
    endtask

    task automatic finish_run;
        $display("Run complete with %0d error(s)", error_cnt);
        if (error_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    task automatic idle_cycles(input int unsigned n);
        repeat (n) @(posedge ACLK);
    endtask

    // Hold req and address through the beat_last cycle
    // Req drops just after that edge
    task automatic run_refill(input int p, input logic [31:0] a);
        @(posedge ACLK);
        #1;
        addr_q[p] = a;
        req_q[p]  = 1'b1;
        @(posedge ACLK);
        while (!beat_last_w[p]) @(posedge ACLK);
        #1;
        req_q[p] = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // AXI read slave model for M0 and M1
    //////////////////////////////////////////////////////////////////////

    always @(posedge ACLK) begin
        // Handshakes of the cycle that just ended
        for (int p = 0; p < 2; p++) begin
            m_took[p] = rvalid_q[p] && rready_w[p];
            if (m_took[p]) begin
                m_idx[p] = m_idx[p] + 4'd1;
                if (m_idx[p] == m_len[p] + 4'd1) begin
                    m_busy[p] = 1'b0;
                end
            end
            if (arvalid_w[p] && arready_q[p]) begin
                m_busy[p] = 1'b1;
                m_addr[p] = araddr_w[p];
                m_len[p]  = arlen_w[p];
                m_idx[p]  = 4'd0;
            end
            if (!ARESETn) begin
                m_busy[p] = 1'b0;
            end
        end
        #1;
        for (int p = 0; p < 2; p++) begin
            arready_q[p] = !m_busy[p] && (random_bits(1) != 32'd0);
            // RVALID holds until taken and then waits a random gap
            if (!rvalid_q[p] || m_took[p]) begin
                if (m_busy[p] && (random_bits(1) != 32'd0)) begin
                    rvalid_q[p] = 1'b1;
                    rdata_q[p]  = (m_addr[p] + (32'(m_idx[p]) << 2)) ^ DATA_XOR[p];
                    rlast_q[p]  = (m_idx[p] == m_len[p]);
                end else begin
                    rvalid_q[p] = 1'b0;
                    rlast_q[p]  = 1'b0;
                end
            end
        end
    end

    // Beat position within the current line
    always @(posedge ACLK) begin
        for (int p = 0; p < 2; p++) begin
            if (!ARESETn || beat_last_w[p]) begin
                beat_cnt[p] <= 4'd0;
            end else if (beat_valid_w[p]) begin
                beat_cnt[p] <= beat_cnt[p] + 4'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Quiet bus after reset
    assert property (@(posedge ACLK) !ARESETn |=>
            arvalid_w == 2'b00 && rready_w == 2'b00 && beat_valid_w == 2'b00)
        else flag_event("bus not quiet after reset");

    assert property (@(posedge ACLK) disable iff (!ARESETn)
            req_q == 2'b00 && arvalid_w == 2'b00 && rready_w == 2'b00 |=>
            arvalid_w == 2'b00 && rready_w == 2'b00 && beat_valid_w == 2'b00)
        else flag_event("bus activity without a request");

    // One port at a time
    assert property (@(posedge ACLK) disable iff (!ARESETn)
            !((arvalid_w[0] || rready_w[0]) && (arvalid_w[1] || rready_w[1])))
        else flag_event("M0 and M1 active in the same cycle");

    for (genvar p = 0; p < 2; p++) begin : g_port_chk
        localparam string SFX = (p == 0) ? "M0" : "M1";

        assert property (@(posedge ACLK) disable iff (!ARESETn)
                arvalid_w[p] && !arready_q[p] |=>
                arvalid_w[p] && $stable(araddr_w[p]) && $stable(arlen_w[p]))
            else flag_event({"ARVALID_", SFX, " or its fields changed before ARREADY"});

        assert property (@(posedge ACLK) disable iff (!ARESETn)
                arvalid_w[p] |-> araddr_w[p] == addr_q[p])
            else flag_value({"ARADDR_", SFX}, $sampled(araddr_w[p]), $sampled(addr_q[p]));

        assert property (@(posedge ACLK) disable iff (!ARESETn)
                arvalid_w[p] |-> arlen_w[p] == expected_len(p, addr_q[p]))
            else flag_value({"ARLEN_", SFX}, 32'($sampled(arlen_w[p])),
                            32'(expected_len(p, $sampled(addr_q[p]))));

        // ID 0 with word size and incrementing burst
        assert property (@(posedge ACLK) disable iff (!ARESETn)
                arvalid_w[p] |-> {arid_w[p], arsize_w[p], arburst_w[p]} == 9'h009)
            else flag_value({"ARID/ARSIZE/ARBURST_", SFX},
                            32'($sampled({arid_w[p], arsize_w[p], arburst_w[p]})), 32'h009);

        // Request into an idle sequencer
        // M0 wins a tie
        assert property (@(posedge ACLK) disable iff (!ARESETn)
                $rose(req_q[p]) && !(p == 1 && req_q[0]) &&
                !arvalid_w[1-p] && !rready_w[1-p] |=> arvalid_w[p])
            else flag_event({"ARVALID_", SFX, " late after request"});

        // Hand-over straight to the waiting port
        assert property (@(posedge ACLK) disable iff (!ARESETn)
                beat_last_w[p] && req_q[1-p] |=> arvalid_w[1-p])
            else flag_event({"no hand-over after last beat on ", SFX});

        assert property (@(posedge ACLK) disable iff (!ARESETn)
                beat_valid_w[p] |->
                beat_data_w[p] == expected_data(p, addr_q[p], beat_cnt[p]))
            else flag_value({"beat_data_", SFX}, $sampled(beat_data_w[p]),
                            expected_data(p, $sampled(addr_q[p]), $sampled(beat_cnt[p])));

        assert property (@(posedge ACLK) disable iff (!ARESETn)
                beat_valid_w[p] |->
                beat_last_w[p] == (beat_cnt[p] == expected_len(p, addr_q[p])))
            else flag_value({"beat_last_", SFX}, 32'($sampled(beat_last_w[p])),
                            32'($sampled(beat_cnt[p]) ==
                                expected_len(p, $sampled(addr_q[p]))));
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    always @(posedge ACLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            flag_event($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
            finish_run();
        end
    end

    initial begin
        ACLK      = 1'b0;
        ARESETn   = 1'b0;
        req_q     = '0;
        addr_q    = '0;
        arready_q = '0;
        rvalid_q  = '0;
        rlast_q   = '0;
        rdata_q   = '0;
        m_busy    = '0;
        m_took    = '0;
        m_idx     = '0;
        m_len     = '0;
        m_addr    = '0;
        // Random traffic drawn up front
        // Data port mixes in I/O segment reads
        for (int i = 0; i < RAND_PER_PORT; i++) begin
            rnd_addr[0][i] = random_bits(30) << 2;
            rnd_gap[0][i]  = random_bits(2);
            if (random_bits(1) != 32'd0) begin
                rnd_addr[1][i] = {`REFILL_UNCACHED_SEG, 16'(random_bits(14) << 2)};
            end else begin
                rnd_addr[1][i] = random_bits(30) << 2;
            end
            rnd_gap[1][i] = random_bits(2);
        end
        repeat (3) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;
        idle_cycles(6);

        // Directed cacheable and uncached lines
        run_refill(0, 32'h0000_1000);
        run_refill(0, 32'h8000_2040);
        run_refill(1, 32'h2000_0100);
        run_refill(1, 32'h0fff_fff0);
        run_refill(1, 32'h1000_0004);
        run_refill(1, 32'h1000_fffc);

        // Both ports at once
        fork
            run_refill(0, 32'h0004_0080);
            run_refill(1, 32'h1000_0040);
        join

        fork
            for (int i = 0; i < RAND_PER_PORT; i++) begin
                idle_cycles(rnd_gap[0][i]);
                run_refill(0, rnd_addr[0][i]);
            end
            for (int i = 0; i < RAND_PER_PORT; i++) begin
                idle_cycles(rnd_gap[1][i]);
                run_refill(1, rnd_addr[1][i]);
            end
        join
        idle_cycles(4);
        finish_run();
    end

endmodule : tb_refill_master

`default_nettype wire

//--- filelist.f
+incdir+logic
logic/axi_pkg.sv
logic/refill_pkg.sv
logic/refill_arbiter.sv
logic/axi_read_port.sv
logic/refill_master_top.sv
sim/tb_refill_master.sv

//--- Makefile
TOP := tb_refill_master
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f $(wildcard logic/*.sv logic/*.svh sim/*.sv)
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
